//--- logic/mixer_pkg.sv
package mixer_pkg;

  localparam int word_width = 64;
  localparam int fifo_depth = 16; // power of two.
  localparam int addr_width = $clog2(fifo_depth);

  // count value of a full fifo, depth is a power of two.
  localparam logic [addr_width:0] fifo_full_count = {1'b1, {addr_width{1'b0}}};

  localparam int hdr_id_bits = 7;
  localparam logic [1:0] ftr_top_bits = 2'b11;
  localparam logic [4:0] ftr_low_bits = 5'b01111;

  localparam logic [word_width-1:0] fill_header = {8'hFE, {(word_width-16){1'b1}}, 8'h00};
  localparam logic [word_width-1:0] fill_footer = {4'b1100, {(word_width-12){1'b1}}, 8'hEF};

  typedef enum logic [1:0] {
    outside,   // between frames.
    in_frame,  // header sent, footer not yet.
    emit_fill, // repair word goes out.
    emit_held  // held word goes out.
  } reader_state_t;

  // top id bits all ones.
  function automatic logic is_header(input logic [word_width-1:0] w);
    return &w[word_width-1 -: hdr_id_bits];
  endfunction

  function automatic logic is_footer(input logic [word_width-1:0] w);
    logic top_ok;
    logic low_ok;
    top_ok = (w[word_width-1 -: $bits(ftr_top_bits)] == ftr_top_bits);
    low_ok = (w[$bits(ftr_low_bits)-1:0] == ftr_low_bits);
    // a header never counts as a footer.
    return !is_header(w) && top_ok && low_ok;
  endfunction

endpackage

//--- logic/channel_fifo.sv
`timescale 1ns/1ps

module channel_fifo (
  input  logic                             CLK,
  input  logic                             RESETN,
  input  logic                             push,
  input  logic [mixer_pkg::word_width-1:0] push_data,
  input  logic                             pop,
  output logic [mixer_pkg::word_width-1:0] head_data,
  output logic                             empty,
  output logic                             dropped
);

  logic [mixer_pkg::word_width-1:0] mem [mixer_pkg::fifo_depth];
  logic [mixer_pkg::addr_width-1:0] wr_ptr;
  logic [mixer_pkg::addr_width-1:0] rd_ptr;
  logic [mixer_pkg::addr_width:0]   count;
  logic                             full;
  logic                             do_push;
  logic                             do_pop;

  assign full    = (count == mixer_pkg::fifo_full_count);
  assign empty   = (count == '0);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // head word is read straight from the array.
  assign head_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one pulse per discarded word.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dropped <= 1'b0;
    end else begin
      dropped <= push & full;
    end
  end

endmodule

//--- logic/frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
  input  logic                             CLK,
  input  logic                             RESETN,
  input  logic                             fifo_empty,
  input  logic [mixer_pkg::word_width-1:0] fifo_data,
  output logic                             fifo_pop,
  output logic                             req,
  input  logic                             gnt,
  output logic                             word_valid,
  output logic [mixer_pkg::word_width-1:0] word_data,
  output logic                             word_last
);

  mixer_pkg::reader_state_t state;
  mixer_pkg::reader_state_t state_nxt;

  logic [mixer_pkg::word_width-1:0] held;
  logic                             capture;
  logic                             hdr_pending; // header kept for the next grant.
  logic                             head_is_hdr;
  logic                             head_is_ftr;
  logic                             held_is_hdr;
  logic                             held_is_ftr;

  assign head_is_hdr = mixer_pkg::is_header(fifo_data);
  assign head_is_ftr = mixer_pkg::is_footer(fifo_data);
  assign held_is_hdr = mixer_pkg::is_header(held);
  assign held_is_ftr = mixer_pkg::is_footer(held);

  assign req = ~gnt & (~fifo_empty | hdr_pending);

  always_comb begin
    state_nxt  = state;
    fifo_pop   = 1'b0;
    capture    = 1'b0;
    word_valid = 1'b0;
    word_last  = 1'b0;
    word_data  = fifo_data;
    case (state)
      mixer_pkg::outside: begin
        if (gnt) begin
          if (hdr_pending) begin
            state_nxt = mixer_pkg::emit_held; // no pop, header already held.
          end else if (!fifo_empty) begin
            fifo_pop = 1'b1;
            if (head_is_hdr) begin
              word_valid = 1'b1;
              state_nxt  = mixer_pkg::in_frame;
            end else begin
              // header lost, fill one in first.
              capture   = 1'b1;
              state_nxt = mixer_pkg::emit_fill;
            end
          end
        end
      end
      mixer_pkg::in_frame: begin
        if (gnt && !fifo_empty) begin
          fifo_pop = 1'b1;
          if (head_is_hdr) begin
            // footer lost, close the frame first.
            capture   = 1'b1;
            state_nxt = mixer_pkg::emit_fill;
          end else begin
            word_valid = 1'b1;
            if (head_is_ftr) begin
              word_last = 1'b1;
              state_nxt = mixer_pkg::outside;
            end
          end
        end
      end
      mixer_pkg::emit_fill: begin
        word_valid = 1'b1;
        if (held_is_hdr) begin
          word_data = mixer_pkg::fill_footer;
          word_last = 1'b1;
          state_nxt = mixer_pkg::outside;
        end else begin
          word_data = mixer_pkg::fill_header;
          state_nxt = mixer_pkg::emit_held;
        end
      end
      mixer_pkg::emit_held: begin
        word_valid = 1'b1;
        word_data  = held;
        if (held_is_ftr) begin
          word_last = 1'b1;
          state_nxt = mixer_pkg::outside;
        end else begin
          state_nxt = mixer_pkg::in_frame;
        end
      end
      default: begin
        state_nxt = mixer_pkg::outside;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= mixer_pkg::outside;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      held <= fifo_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      hdr_pending <= 1'b0;
    end else begin
      if (state == mixer_pkg::emit_fill && held_is_hdr) begin
        hdr_pending <= 1'b1;
      end else if (state == mixer_pkg::emit_held) begin
        hdr_pending <= 1'b0; // held word is out.
      end
    end
  end

endmodule

//--- logic/frame_arbiter.sv
`timescale 1ns/1ps

module frame_arbiter (
  input  logic                             CLK,
  input  logic                             RESETN,
  input  logic                             ready,
  input  logic                             req0,
  input  logic                             req1,
  output logic                             gnt0,
  output logic                             gnt1,
  input  logic                             valid0,
  input  logic [mixer_pkg::word_width-1:0] data0,
  input  logic                             last0,
  input  logic                             valid1,
  input  logic [mixer_pkg::word_width-1:0] data1,
  input  logic                             last1,
  output logic                             out_valid,
  output logic [mixer_pkg::word_width-1:0] out_data,
  output logic                             out_ch,
  output logic                             out_last
);

  logic                             busy;
  logic                             owner; // channel that holds the bus.
  logic                             sel_valid;
  logic [mixer_pkg::word_width-1:0] sel_data;
  logic                             sel_last;

  assign gnt0 = busy & ~owner;
  assign gnt1 = busy & owner;

  assign sel_valid = busy & (owner ? valid1 : valid0);
  assign sel_data  = owner ? data1 : data0;
  assign sel_last  = owner ? last1 : last0;

  // ready only matters when a frame starts.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      busy  <= 1'b0;
      owner <= 1'b0;
    end else begin
      if (!busy) begin
        if (ready && req0) begin
          busy  <= 1'b1;
          owner <= 1'b0;
        end else if (ready && req1) begin
          busy  <= 1'b1;
          owner <= 1'b1;
        end
      end else if (sel_valid && sel_last) begin
        busy <= 1'b0; // frame done.
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_data  <= '0;
      out_ch    <= 1'b0;
    end else begin
      out_valid <= sel_valid;
      out_last  <= sel_valid & sel_last;
      if (sel_valid) begin
        out_data <= sel_data;
        out_ch   <= owner;
      end
    end
  end

endmodule

//--- logic/frame_mixer_top.sv
`timescale 1ns/1ps

module frame_mixer_top (
  input  logic                             CLK,
  input  logic                             RESETN,
  input  logic                             ch0_push,
  input  logic [mixer_pkg::word_width-1:0] ch0_data,
  input  logic                             ch1_push,
  input  logic [mixer_pkg::word_width-1:0] ch1_data,
  input  logic                             ready,
  output logic                             out_valid,
  output logic [mixer_pkg::word_width-1:0] out_data,
  output logic                             out_ch,
  output logic                             out_last,
  output logic                             ch0_dropped,
  output logic                             ch1_dropped
);

  logic [mixer_pkg::word_width-1:0] head0;
  logic [mixer_pkg::word_width-1:0] head1;
  logic [mixer_pkg::word_width-1:0] word0;
  logic [mixer_pkg::word_width-1:0] word1;
  logic empty0;
  logic empty1;
  logic pop0;
  logic pop1;
  logic req0;
  logic req1;
  logic gnt0;
  logic gnt1;
  logic valid0;
  logic valid1;
  logic last0;
  logic last1;

  channel_fifo u_fifo0 (
    .CLK(CLK), .RESETN(RESETN),
    .push(ch0_push), .push_data(ch0_data),
    .pop(pop0), .head_data(head0), .empty(empty0), .dropped(ch0_dropped)
  );

  channel_fifo u_fifo1 (
    .CLK(CLK), .RESETN(RESETN),
    .push(ch1_push), .push_data(ch1_data),
    .pop(pop1), .head_data(head1), .empty(empty1), .dropped(ch1_dropped)
  );

  frame_reader u_reader0 (
    .CLK(CLK), .RESETN(RESETN),
    .fifo_empty(empty0), .fifo_data(head0), .fifo_pop(pop0),
    .req(req0), .gnt(gnt0),
    .word_valid(valid0), .word_data(word0), .word_last(last0)
  );

  frame_reader u_reader1 (
    .CLK(CLK), .RESETN(RESETN),
    .fifo_empty(empty1), .fifo_data(head1), .fifo_pop(pop1),
    .req(req1), .gnt(gnt1),
    .word_valid(valid1), .word_data(word1), .word_last(last1)
  );

  // channel 0 wins a tie.
  frame_arbiter u_arbiter (
    .CLK(CLK), .RESETN(RESETN), .ready(ready),
    .req0(req0), .req1(req1), .gnt0(gnt0), .gnt1(gnt1),
    .valid0(valid0), .data0(word0), .last0(last0),
    .valid1(valid1), .data1(word1), .last1(last1),
    .out_valid(out_valid), .out_data(out_data), .out_ch(out_ch), .out_last(out_last)
  );

endmodule

//--- bench/frame_model.svh
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

typedef logic [mixer_pkg::word_width-1:0] word_t;
typedef logic [mixer_pkg::word_width:0] out_word_t; // last flag on top.
typedef word_t word_q_t [$];
typedef out_word_t out_q_t [$];

function automatic logic word_is_header(input word_t w);
  return w[mixer_pkg::word_width-1 -: 7] == 7'h7f;
endfunction

// a header never reads as a footer.
function automatic logic word_is_footer(input word_t w);
  logic marks;
  marks = (w[mixer_pkg::word_width-1 -: 2] == 2'b11) && (w[4:0] == 5'b01111);
  return marks && !word_is_header(w);
endfunction

function automatic word_t make_header(input logic [15:0] tag);
  return {7'h7f, {(mixer_pkg::word_width-23){1'b0}}, tag};
endfunction

function automatic word_t make_footer(input logic [15:0] tag);
  return {2'b11, {(mixer_pkg::word_width-23){1'b0}}, tag, 5'b01111};
endfunction

function automatic word_t make_data(input logic [15:0] tag);
  return {{(mixer_pkg::word_width-16){1'b0}}, tag};
endfunction

// expected out words of one channel, from its accepted pushes.
function automatic out_q_t repair_stream(input word_q_t pushed);
  out_q_t res;
  mixer_pkg::reader_state_t st;
  word_t w;
  st = mixer_pkg::outside;
  foreach (pushed[i]) begin
    w = pushed[i];
    if (st == mixer_pkg::outside && !word_is_header(w)) begin
      res.push_back({1'b0, 8'hfe, {(mixer_pkg::word_width-16){1'b1}}, 8'h00});
    end else if (st == mixer_pkg::in_frame && word_is_header(w)) begin
      res.push_back({1'b1, 4'b1100, {(mixer_pkg::word_width-12){1'b1}}, 8'hef});
    end
    res.push_back({word_is_footer(w), w});
    if (word_is_footer(w)) begin
      st = mixer_pkg::outside;
    end else begin
      st = mixer_pkg::in_frame;
    end
  end
  return res;
endfunction

`endif

//--- bench/mixer_tb.sv
`timescale 1ns/1ps

module mixer_tb;

  `include "frame_model.svh"

  logic  CLK;
  logic  RESETN;
  logic  ch0_push;
  word_t ch0_data;
  logic  ch1_push;
  word_t ch1_data;
  logic  ready;
  logic  out_valid;
  word_t out_data;
  logic  out_ch;
  logic  out_last;
  logic  ch0_dropped;
  logic  ch1_dropped;

  word_q_t sent0;
  word_q_t sent1;
  out_q_t  got0;
  out_q_t  got1;
  int      errors;
  int      timeouts;
  int      drops0;
  int      drops1;
  logic    quiet;      // ready is low, bus must stay idle.
  logic    first_seen;
  logic    first_ch;
  logic    frame_open;
  logic    frame_ch;
  integer  seed;

  frame_mixer_top DUT (
    .CLK(CLK), .RESETN(RESETN),
    .ch0_push(ch0_push), .ch0_data(ch0_data),
    .ch1_push(ch1_push), .ch1_data(ch1_data),
    .ready(ready),
    .out_valid(out_valid), .out_data(out_data), .out_ch(out_ch), .out_last(out_last),
    .ch0_dropped(ch0_dropped), .ch1_dropped(ch1_dropped)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // output monitor.
  always @(posedge CLK) begin
    if (RESETN) begin
      if (ch0_dropped) drops0++;
      if (ch1_dropped) drops1++;
      if (quiet) begin
        assert (!out_valid) else begin
          $display("** Error out_valid: got %h expected %h", out_valid, 1'b0);
          errors++;
        end
      end
      if (out_valid) begin
        if (!first_seen) begin
          first_seen = 1'b1;
          first_ch   = out_ch;
        end
        if (frame_open) begin
          assert (out_ch == frame_ch) else begin
            $display("** Error out_ch: got %h expected %h", out_ch, frame_ch);
            errors++;
          end
        end
        frame_open = !out_last;
        frame_ch   = out_ch;
        if (out_ch) got1.push_back({out_last, out_data});
        else got0.push_back({out_last, out_data});
      end
    end
  end

  function automatic word_t random_word();
    word_t w;
    int kind;
    kind = $unsigned($random(seed)) % 4;
    w = {$random(seed), $random(seed)};
    if (kind == 2) begin
      w[mixer_pkg::word_width-1 -: 7] = 7'h7f;
    end else if (kind == 3) begin
      w[mixer_pkg::word_width-1 -: 2] = 2'b11;
      w[mixer_pkg::word_width-7] = 1'b0; // not a header.
      w[4:0] = 5'b01111;
    end
    return w;
  endfunction

  task automatic set_ready(input logic level);
    @(posedge CLK);
    ready <= level;
  endtask

  // one word per channel per cycle.
  task automatic push_lists(input word_q_t list0, input word_q_t list1);
    int n;
    n = (list0.size() > list1.size()) ? list0.size() : list1.size();
    for (int i = 0; i < n; i++) begin
      @(posedge CLK);
      ch0_push <= (i < list0.size());
      ch1_push <= (i < list1.size());
      if (i < list0.size()) begin
        ch0_data <= list0[i];
        sent0.push_back(list0[i]);
      end
      if (i < list1.size()) begin
        ch1_data <= list1[i];
        sent1.push_back(list1[i]);
      end
    end
    @(posedge CLK);
    ch0_push <= 1'b0;
    ch1_push <= 1'b0;
  endtask

  task automatic compare_stream(input int ch, input out_q_t got, input out_q_t exp,
                                input string name);
    out_word_t g;
    out_word_t e;
    int n;
    assert (got.size() == exp.size()) else begin
      $display("** Error ch%0d word count (%s): got %h expected %h",
               ch, name, got.size(), exp.size());
      errors++;
    end
    n = (got.size() < exp.size()) ? got.size() : exp.size();
    for (int i = 0; i < n; i++) begin
      g = got[i];
      e = exp[i];
      assert (g[mixer_pkg::word_width-1:0] == e[mixer_pkg::word_width-1:0]) else begin
        $display("** Error out_data (%s, ch%0d word %0d): got %h expected %h", name, ch, i,
                 g[mixer_pkg::word_width-1:0], e[mixer_pkg::word_width-1:0]);
        errors++;
      end
      assert (g[mixer_pkg::word_width] == e[mixer_pkg::word_width]) else begin
        $display("** Error out_last (%s, ch%0d word %0d): got %h expected %h", name, ch, i,
                 g[mixer_pkg::word_width], e[mixer_pkg::word_width]);
        errors++;
      end
    end
  endtask

  task automatic drain_and_compare(input string name);
    out_q_t exp0;
    out_q_t exp1;
    int cycles;
    if (timeouts != 0) return;
    exp0 = repair_stream(sent0);
    exp1 = repair_stream(sent1);
    cycles = 0;
    while ((got0.size() < exp0.size() || got1.size() < exp1.size()) && cycles < 1000) begin
      @(posedge CLK);
      cycles++;
    end
    if (got0.size() < exp0.size() || got1.size() < exp1.size()) begin
      timeouts++;
      $display("timeout: %s did not deliver all expected words", name);
    end else begin
      repeat (8) @(posedge CLK); // room for stray extra words.
      compare_stream(0, got0, exp0, name);
      compare_stream(1, got1, exp1, name);
    end
    sent0.delete();
    sent1.delete();
    got0.delete();
    got1.delete();
  endtask

  task automatic check_both_loaded();
    word_q_t l0;
    word_q_t l1;
    set_ready(1'b0);
    l0 = '{make_header(16'h0401), make_data(16'h0402), make_data(16'h0403),
           make_footer(16'h0404), make_header(16'h0405), make_data(16'h0406),
           make_footer(16'h0407)};
    l1 = '{make_header(16'h0411), make_data(16'h0412), make_footer(16'h0413),
           make_header(16'h0414), make_data(16'h0415), make_data(16'h0416),
           make_data(16'h0417), make_footer(16'h0418)};
    push_lists(l0, l1);
    first_seen = 1'b0;
    set_ready(1'b1);
    drain_and_compare("both channels loaded");
    assert (first_seen && first_ch == 1'b0) else begin
      $display("** Error out_ch: first frame got %h expected %h", first_ch, 1'b0);
      errors++;
    end
  endtask

  task automatic check_full_fifo();
    word_q_t l0;
    word_q_t l1;
    logic [15:0] tag;
    int cycles;
    set_ready(1'b0);
    quiet = 1'b1;
    tag = 16'h0500;
    repeat (4) begin
      l0.push_back(make_header(tag));
      l0.push_back(make_data(tag + 16'h0001));
      l0.push_back(make_data(tag + 16'h0002));
      l0.push_back(make_footer(tag + 16'h0003));
      tag = tag + 16'h0010;
    end
    l0.push_back(make_data(16'h05ff)); // seventeenth word.
    push_lists(l0, l1);
    cycles = 0;
    while (drops0 < 1 && cycles < 20) begin
      @(posedge CLK);
      cycles++;
    end
    if (drops0 < 1) begin
      timeouts++;
      $display("timeout: channel 0 never flagged the push into its full FIFO");
    end
    repeat (10) @(posedge CLK);
    void'(sent0.pop_back());
    quiet = 1'b0;
    set_ready(1'b1);
    drain_and_compare("full fifo");
  endtask

  task automatic check_random_mix();
    word_q_t l0;
    word_q_t l1;
    int n0;
    int n1;
    repeat (6) begin
      l0.delete();
      l1.delete();
      n0 = 4 + ($unsigned($random(seed)) % 9);
      n1 = 4 + ($unsigned($random(seed)) % 9);
      for (int i = 0; i < n0 - 1; i++) l0.push_back(random_word());
      for (int i = 0; i < n1 - 1; i++) l1.push_back(random_word());
      l0.push_back(make_footer(16'h06f0)); // closes any open frame.
      l1.push_back(make_footer(16'h06f1));
      push_lists(l0, l1);
      drain_and_compare("random mix");
    end
  endtask

  initial begin
    word_q_t l0;
    word_q_t l1;
    seed       = 32'hcbc5605c;
    errors     = 0;
    timeouts   = 0;
    drops0     = 0;
    drops1     = 0;
    quiet      = 1'b0;
    first_seen = 1'b0;
    first_ch   = 1'b0;
    frame_open = 1'b0;
    frame_ch   = 1'b0;
    RESETN     = 1'b0;
    ch0_push   = 1'b0;
    ch0_data   = '0;
    ch1_push   = 1'b0;
    ch1_data   = '0;
    ready      = 1'b1;
    repeat (2) @(posedge CLK);
    RESETN <= 1'b1;

    l0 = '{make_header(16'h0101), make_data(16'h0102), make_data(16'h0103),
           make_footer(16'h0104)};
    push_lists(l0, l1);
    drain_and_compare("single frame");

    l0 = '{make_data(16'h0201), make_data(16'h0202), make_footer(16'h0203)};
    l1 = '{make_data(16'h0211), make_footer(16'h0212)};
    push_lists(l0, l1);
    drain_and_compare("missing header");
    l1.delete();

    l0 = '{make_header(16'h0301), make_data(16'h0302), make_header(16'h0303),
           make_data(16'h0304), make_footer(16'h0305)};
    push_lists(l0, l1);
    drain_and_compare("missing footer");

    if (timeouts == 0) check_both_loaded();
    if (timeouts == 0) check_full_fifo();
    if (timeouts == 0) check_random_mix();

    assert (drops0 == 1 && drops1 == 0) else begin
      $display("** Error ch0_dropped/ch1_dropped pulses: got %h/%h expected %h/%h",
               drops0, drops1, 1, 0);
      errors++;
    end
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+bench
logic/mixer_pkg.sv
logic/channel_fifo.sv
logic/frame_reader.sv
logic/frame_arbiter.sv
logic/frame_mixer_top.sv
bench/mixer_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module mixer_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vmixer_tb)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
